/* design/esp_pkg.sv */
`default_nettype none

package esp_pkg;

  // command codes from the ESP, numbering kept from the board firmware
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    data_ready       = 8'd5,
    get_version      = 8'd15,
    get_printer_byte = 8'd16,
    set_screen_color = 8'd17,
    abus_read        = 8'd18,
    send_keyb        = 8'd19,
    set_led          = 8'd26
  } cmd_e;

  // access kind reported on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    printer_wr = 4'd4,
    idle       = 4'hF
  } esp_status_e;

  typedef struct packed {
    cmd_e            code;
    logic [2:0][7:0] params; // params[0] arrives first
  } cmd_msg_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
    logic        rd_n;
    logic        wr_n;
    logic        in_n;
    logic        out_n;
  } trs_bus_t;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
  } led_t;

  localparam logic [7:0]  COOKIE        = 8'hAF;
  localparam logic [7:0]  VERSION       = {3'd0, 5'd3}; // major, minor
  localparam logic [7:0]  PRINTER_READY = 8'h30;
  localparam logic [7:0]  PRINTER_BUSY  = 8'hF0;
  localparam logic [7:0]  TRS_IO_PORT   = 8'd31;
  localparam logic [3:0]  FREHD_PORT_HI = 4'hC;    // ports 0xC0..0xCF
  localparam logic [15:0] PRINTER_ADDR  = 16'h37E8;

  // parameter bytes following the command byte
  function automatic logic [1:0] param_count(input cmd_e code);
    case (code)
      set_led:          return 2'd1;
      send_keyb:        return 2'd2;
      set_screen_color: return 2'd3;
      default:          return 2'd0;
    endcase
  endfunction

  // commands answered with one extra byte on miso
  function automatic logic has_reply(input cmd_e code);
    return (code == get_cookie) || (code == get_version) ||
           (code == get_printer_byte) || (code == abus_read);
  endfunction

endpackage

`default_nettype wire

/* design/sync_edge.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_edge #(
  parameter int STAGES = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic din,
  output logic level,
  output logic rise,
  output logic fall
);

  logic [STAGES:0] sr; // one extra stage for edge compare

  always_ff @(posedge clk) begin
    if (rst) begin
      sr <= '0;
    end else begin
      sr <= {sr[STAGES-1:0], din};
    end
  end

  assign level = sr[STAGES-1];
  assign rise  = sr[STAGES-1] & ~sr[STAGES]; // 0 -> 1
  assign fall  = ~sr[STAGES-1] & sr[STAGES]; // 1 -> 0

endmodule

`default_nettype wire

/* design/spi_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_slave #(
  parameter int STAGES = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  input  logic [7:0] reply_byte,
  input  logic       reply_load
);

  logic       sck_rise;
  logic       sck_fall;
  logic       cs_n_s;
  logic       mosi_s;
  logic       cs_active;
  logic [2:0] bit_cnt;
  logic [7:0] shift_in;
  logic [7:0] shift_out;
  logic [3:0] reply_cnt; // reply bits still owed to the master

  sync_edge #(.STAGES(STAGES)) sck_sync_i (
    .clk(clk), .rst(rst), .din(sck), .level(), .rise(sck_rise), .fall(sck_fall)
  );
  sync_edge #(.STAGES(STAGES)) cs_sync_i (
    .clk(clk), .rst(rst), .din(cs_n), .level(cs_n_s), .rise(), .fall()
  );
  sync_edge #(.STAGES(STAGES)) mosi_sync_i (
    .clk(clk), .rst(rst), .din(mosi), .level(mosi_s), .rise(), .fall()
  );

  assign cs_active = ~cs_n_s;

  // bit position, cleared whenever cs is released
  always_ff @(posedge clk) begin
    if (rst || !cs_active) begin
      bit_cnt <= '0;
    end else if (sck_rise) begin
      bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      shift_in <= {shift_in[6:0], mosi_s}; // msb first
    end
  end

  assign rx_byte = shift_in;

  // byte complete on 8th rising edge, unless it is the reply slot
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7) && (reply_cnt == 4'd0);
    end
  end

  // reply shifter
  // the trailing falling edge of the previous byte is skipped (cnt still 8)
  always_ff @(posedge clk) begin
    if (rst) begin
      reply_cnt <= '0;
      shift_out <= '0;
    end else if (reply_load) begin
      reply_cnt <= 4'd8;
      shift_out <= reply_byte; // msb straight onto miso
    end else if (!cs_active) begin
      reply_cnt <= '0;
    end else begin
      if (sck_rise && reply_cnt != 4'd0) begin
        reply_cnt <= reply_cnt - 4'd1; // master sampled one bit
      end
      if (sck_fall && reply_cnt != 4'd0 && reply_cnt != 4'd8) begin
        shift_out <= {shift_out[6:0], 1'b0};
      end
    end
  end

  assign miso = shift_out[7];

endmodule

`default_nettype wire

/* design/cmd_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_parser (
  input  logic             clk,
  input  logic             rst,
  input  logic [7:0]       rx_byte,
  input  logic             rx_valid,
  output esp_pkg::cmd_msg_t msg,
  output logic             msg_valid
);

  typedef enum logic {
    idle,
    read_bytes
  } state_e;

  state_e          state;
  esp_pkg::cmd_e   code_in;
  logic            known;
  logic [1:0]      remaining; // param bytes still to come
  logic [1:0]      idx;       // next params slot

  assign code_in = esp_pkg::cmd_e'(rx_byte);

  // codes this bridge handles, anything else is dropped
  always_comb begin
    case (code_in)
      esp_pkg::get_cookie, esp_pkg::data_ready, esp_pkg::get_version,
      esp_pkg::get_printer_byte, esp_pkg::set_screen_color,
      esp_pkg::abus_read, esp_pkg::send_keyb, esp_pkg::set_led: known = 1'b1;
      default: known = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      msg_valid <= 1'b0;
      remaining <= '0;
      idx       <= '0;
    end else begin
      msg_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          idle: begin
            if (known) begin
              msg.code  <= code_in;
              idx       <= '0;
              remaining <= esp_pkg::param_count(code_in);
              if (esp_pkg::param_count(code_in) == 2'd0) begin
                msg_valid <= 1'b1; // no params, message done
              end else begin
                state <= read_bytes;
              end
            end
          end
          read_bytes: begin
            msg.params[idx] <= rx_byte;
            idx             <= idx + 2'd1;
            if (remaining == 2'd1) begin
              msg_valid <= 1'b1;
              state     <= idle;
            end else begin
              remaining <= remaining - 2'd1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/cmd_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_exec #(
  parameter int KEYB_ROWS = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  esp_pkg::cmd_msg_t msg,
  input  logic              msg_valid,
  input  logic [7:0]        printer_byte,
  input  logic [7:0]        addr_lo,
  output esp_pkg::led_t     led,
  output logic [23:0]       screen_color,
  output logic              key_pressed,
  output logic [7:0]        reply_byte,
  output logic              reply_load
);

  localparam int ROW_W = (KEYB_ROWS > 1) ? $clog2(KEYB_ROWS) : 1;

  logic [7:0]       keyb_matrix [KEYB_ROWS];
  logic [ROW_W-1:0] row_idx;

  assign row_idx = ROW_W'(msg.params[0] % KEYB_ROWS); // row wraps

  always_ff @(posedge clk) begin
    if (rst) begin
      led          <= '0;
      screen_color <= 24'hFFFFFF; // white
      reply_load   <= 1'b0;
      for (int i = 0; i < KEYB_ROWS; i++) begin
        keyb_matrix[i] <= '0;
      end
    end else begin
      reply_load <= msg_valid && esp_pkg::has_reply(msg.code);
      if (msg_valid) begin
        case (msg.code)
          esp_pkg::set_led: begin
            led.red   <= msg.params[0][0];
            led.green <= msg.params[0][1];
            led.blue  <= msg.params[0][2];
          end
          esp_pkg::set_screen_color: begin
            screen_color <= {msg.params[0], msg.params[1], msg.params[2]}; // r, g, b
          end
          esp_pkg::send_keyb: keyb_matrix[row_idx] <= msg.params[1];
          default: ;
        endcase
      end
    end
  end

  // reply value, sent on the byte after the command
  always_ff @(posedge clk) begin
    if (msg_valid) begin
      case (msg.code)
        esp_pkg::get_cookie:       reply_byte <= esp_pkg::COOKIE;
        esp_pkg::get_version:      reply_byte <= esp_pkg::VERSION;
        esp_pkg::get_printer_byte: reply_byte <= printer_byte;
        esp_pkg::abus_read:        reply_byte <= addr_lo;
        default: ;
      endcase
    end
  end

  // any key down in any row
  always_comb begin
    key_pressed = 1'b0;
    for (int i = 0; i < KEYB_ROWS; i++) begin
      key_pressed = key_pressed | (|keyb_matrix[i]);
    end
  end

endmodule

`default_nettype wire

/* design/io_request.sv */
`timescale 1ns/1ps
`default_nettype none

module io_request #(
  parameter int REQ_CYCLES = 50,
  parameter int STAGES     = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  esp_pkg::trs_bus_t    bus,
  input  logic                 done,
  input  esp_pkg::cmd_msg_t    msg,
  input  logic                 msg_valid,
  output logic                 req,
  output logic                 wait_req,
  output logic                 intr,
  output esp_pkg::esp_status_e esp_s,
  output logic [7:0]           rd_data,
  output logic [7:0]           printer_byte
);

  localparam int CNT_W = $clog2(REQ_CYCLES + 1);

  logic                 any_strobe;
  logic                 access_rise;
  logic                 done_rise;
  logic                 sel_io_in;
  logic                 sel_io_out;
  logic                 sel_frehd_in;
  logic                 sel_frehd_out;
  logic                 sel_prn_wr;
  logic                 sel_prn_rd;
  logic                 esp_sel;
  esp_pkg::esp_status_e kind;
  logic [CNT_W-1:0]     count;
  logic [7:0]           printer_status;

  assign any_strobe = ~(bus.rd_n & bus.wr_n & bus.in_n & bus.out_n);

  sync_edge #(.STAGES(STAGES)) access_sync_i (
    .clk(clk), .rst(rst), .din(any_strobe), .level(), .rise(access_rise), .fall()
  );
  sync_edge #(.STAGES(STAGES)) done_sync_i (
    .clk(clk), .rst(rst), .din(done), .level(), .rise(done_rise), .fall()
  );

  // address decode, each under its own strobe
  assign sel_io_in     = (bus.addr[7:0] == esp_pkg::TRS_IO_PORT) && !bus.in_n;
  assign sel_io_out    = (bus.addr[7:0] == esp_pkg::TRS_IO_PORT) && !bus.out_n;
  assign sel_frehd_in  = (bus.addr[7:4] == esp_pkg::FREHD_PORT_HI) && !bus.in_n;
  assign sel_frehd_out = (bus.addr[7:4] == esp_pkg::FREHD_PORT_HI) && !bus.out_n;
  assign sel_prn_wr    = (bus.addr == esp_pkg::PRINTER_ADDR) && !bus.wr_n;
  assign sel_prn_rd    = (bus.addr == esp_pkg::PRINTER_ADDR) && !bus.rd_n;

  assign esp_sel = sel_io_in | sel_io_out | sel_frehd_in | sel_frehd_out | sel_prn_wr;

  always_comb begin
    if (sel_io_in)          kind = esp_pkg::trs_io_in;
    else if (sel_io_out)    kind = esp_pkg::trs_io_out;
    else if (sel_frehd_in)  kind = esp_pkg::frehd_in;
    else if (sel_frehd_out) kind = esp_pkg::frehd_out;
    else if (sel_prn_wr)    kind = esp_pkg::printer_wr;
    else                    kind = esp_pkg::idle;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req            <= 1'b0;
      wait_req       <= 1'b0;
      count          <= '0;
      esp_s          <= esp_pkg::idle;
      printer_status <= esp_pkg::PRINTER_READY;
    end else begin
      if (count == CNT_W'(1)) req <= 1'b0; // pulse over
      if (count != '0) count <= count - CNT_W'(1);
      if (access_rise && esp_sel) begin
        req   <= 1'b1;
        count <= CNT_W'(REQ_CYCLES); // restarts even mid-pulse
        esp_s <= kind;
        if (sel_prn_wr) begin
          printer_status <= esp_pkg::PRINTER_BUSY; // printer does not stall the cpu
        end else begin
          wait_req <= 1'b1;
        end
      end else if (done_rise) begin
        wait_req       <= 1'b0;
        esp_s          <= esp_pkg::idle;
        printer_status <= esp_pkg::PRINTER_READY;
      end
    end
  end

  // printer data latch and status readback
  always_ff @(posedge clk) begin
    if (access_rise && sel_prn_wr) printer_byte <= bus.data;
    if (access_rise && sel_prn_rd) rd_data <= printer_status;
  end

  // data-ready interrupt, set by esp, cleared by any port 31 access
  always_ff @(posedge clk) begin
    if (rst) begin
      intr <= 1'b0;
    end else if (access_rise && (sel_io_in || sel_io_out)) begin
      intr <= 1'b0;
    end else if (msg_valid && msg.code == esp_pkg::data_ready) begin
      intr <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/trs_esp_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_esp_bridge #(
  parameter int REQ_CYCLES = 50,
  parameter int KEYB_ROWS  = 8,
  parameter int STAGES     = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sck,
  input  logic                 cs_n,
  input  logic                 mosi,
  output logic                 miso,
  input  logic                 done,
  input  esp_pkg::trs_bus_t    bus,
  output logic                 req,
  output logic                 wait_req,
  output esp_pkg::esp_status_e esp_s,
  output logic                 intr,
  output logic [7:0]           rd_data,
  output esp_pkg::led_t        led,
  output logic [23:0]          screen_color,
  output logic                 key_pressed
);

  logic [7:0]        rx_byte;
  logic              rx_valid;
  esp_pkg::cmd_msg_t msg;
  logic              msg_valid;
  logic [7:0]        reply_byte;
  logic              reply_load;
  logic [7:0]        printer_byte;

  // esp link, bytes in and reply out
  spi_slave #(.STAGES(STAGES)) spi_slave_i (
    .clk(clk), .rst(rst), .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .rx_byte(rx_byte), .rx_valid(rx_valid),
    .reply_byte(reply_byte), .reply_load(reply_load)
  );

  cmd_parser cmd_parser_i (
    .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .msg(msg), .msg_valid(msg_valid)
  );

  cmd_exec #(.KEYB_ROWS(KEYB_ROWS)) cmd_exec_i (
    .clk(clk), .rst(rst), .msg(msg), .msg_valid(msg_valid),
    .printer_byte(printer_byte), .addr_lo(bus.addr[7:0]),
    .led(led), .screen_color(screen_color), .key_pressed(key_pressed),
    .reply_byte(reply_byte), .reply_load(reply_load)
  );

  // trs-80 bus side
  io_request #(.REQ_CYCLES(REQ_CYCLES), .STAGES(STAGES)) io_request_i (
    .clk(clk), .rst(rst), .bus(bus), .done(done), .msg(msg), .msg_valid(msg_valid),
    .req(req), .wait_req(wait_req), .intr(intr), .esp_s(esp_s),
    .rd_data(rd_data), .printer_byte(printer_byte)
  );

endmodule

`default_nettype wire

/* bench/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam int SCK_HALF   = 16;   // clk cycles per sck half period
localparam int WAIT_LIMIT = 1000; // clk cycles per wait loop
localparam int STB_RD     = 0;
localparam int STB_WR     = 1;
localparam int STB_IN     = 2;
localparam int STB_OUT    = 3;

task automatic report_fail(input string name, input logic [31:0] exp, input logic [31:0] act);
  $display("Fail %s: expected %0h, actual %0h", name, exp, act);
  errors++;
endtask

// mode 0 master with msb first and miso read just before each rising edge
task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
  for (int i = 7; i >= 0; i--) begin
    mosi = tx[i];
    repeat (SCK_HALF) @(negedge clk);
    rx[i] = miso;
    sck = 1'b1;
    repeat (SCK_HALF) @(negedge clk);
    sck = 1'b0; // slave shifts next reply bit here
  end
endtask

// one cs frame of command and params plus an optional reply slot
task automatic run_frame(input logic [7:0] code, input logic [7:0] p0, input logic [7:0] p1,
                         input logic [7:0] p2, input int nparams, input logic want_reply,
                         output logic [7:0] reply);
  logic [7:0] params [3];
  logic [7:0] unused;
  params[0] = p0;
  params[1] = p1;
  params[2] = p2;
  cs_n = 1'b0;
  repeat (SCK_HALF) @(negedge clk);
  spi_byte(code, unused);
  for (int i = 0; i < nparams; i++) begin
    spi_byte(params[i], unused);
  end
  reply = 8'h00;
  if (want_reply) begin
    spi_byte(8'h00, reply);
  end
  repeat (SCK_HALF) @(negedge clk);
  cs_n = 1'b1;
  repeat (SCK_HALF) @(negedge clk);
endtask

// one strobe low for 20 cycles
task automatic bus_access(input logic [15:0] addr, input logic [7:0] data, input int strobe);
  bus.addr = addr;
  bus.data = data;
  case (strobe)
    STB_RD:  bus.rd_n = 1'b0;
    STB_WR:  bus.wr_n = 1'b0;
    STB_IN:  bus.in_n = 1'b0;
    default: bus.out_n = 1'b0;
  endcase
  repeat (20) @(negedge clk);
  bus.rd_n  = 1'b1;
  bus.wr_n  = 1'b1;
  bus.in_n  = 1'b1;
  bus.out_n = 1'b1;
  repeat (6) @(negedge clk); // synced strobe drops again
endtask

task automatic pulse_done();
  done = 1'b1;
  repeat (6) @(negedge clk);
  done = 1'b0;
endtask

task automatic wait_req_low();
  int n;
  n = 0;
  while (req !== 1'b0 && n < WAIT_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (req !== 1'b0) begin
    $display("Timeout, req still high after %0d cycles", WAIT_LIMIT);
    errors++;
  end
endtask

// wait level gone after done
task automatic wait_release();
  int n;
  n = 0;
  while (wait_req !== 1'b0 && n < WAIT_LIMIT) begin
    @(negedge clk);
    n++;
  end
  if (wait_req !== 1'b0) begin
    $display("Timeout, wait_req still high after done");
    errors++;
  end
endtask

task automatic model_reset();
  exp_led   = 3'b000;
  exp_color = 24'hFFFFFF;
  exp_prn   = 8'h00;
  exp_intr  = 1'b0;
  for (int i = 0; i < KEYB_ROWS; i++) begin
    exp_rows[i] = 8'h00;
  end
endtask

function automatic logic keys_any();
  logic any;
  any = 1'b0;
  for (int i = 0; i < KEYB_ROWS; i++) begin
    any = any | (|exp_rows[i]);
  end
  return any;
endfunction

`endif

/* bench/tb_trs_esp_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trs_esp_bridge;

  localparam int REQ_CYCLES = 50;
  localparam int KEYB_ROWS  = 8;
  localparam int STAGES     = 2;

  logic                 clk;
  logic                 rst;
  logic                 sck;
  logic                 cs_n;
  logic                 mosi;
  logic                 miso;
  logic                 done;
  esp_pkg::trs_bus_t    bus;
  logic                 req;
  logic                 wait_req;
  esp_pkg::esp_status_e esp_s;
  logic                 intr;
  logic [7:0]           rd_data;
  esp_pkg::led_t        led;
  logic [23:0]          screen_color;
  logic                 key_pressed;

  int   errors;
  logic req_seen; // req observed high since last clear

  // reference model
  logic [2:0]  exp_led;
  logic [23:0] exp_color;
  logic [7:0]  exp_rows [KEYB_ROWS];
  logic [7:0]  exp_prn;
  logic        exp_intr;

  `include "tb_tasks.svh"

  trs_esp_bridge #(
    .REQ_CYCLES(REQ_CYCLES), .KEYB_ROWS(KEYB_ROWS), .STAGES(STAGES)
  ) trs_esp_bridge_i (
    .clk(clk), .rst(rst), .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .done(done), .bus(bus), .req(req), .wait_req(wait_req), .esp_s(esp_s),
    .intr(intr), .rd_data(rd_data), .led(led), .screen_color(screen_color),
    .key_pressed(key_pressed)
  );

  always #2 clk = ~clk; // 4 ns period

  always @(posedge clk) begin
    if (req) req_seen <= 1'b1;
  end

  task automatic reset_values();
    if (req !== 1'b0) report_fail("reset req", 0, req);
    if (wait_req !== 1'b0) report_fail("reset wait_req", 0, wait_req);
    if (intr !== exp_intr) report_fail("reset intr", exp_intr, intr);
    if (key_pressed !== keys_any()) report_fail("reset key_pressed", keys_any(), key_pressed);
    if (esp_s !== 4'hF) report_fail("reset esp_s", 4'hF, esp_s);
    if (led !== exp_led) report_fail("reset led", exp_led, led);
    if (screen_color !== exp_color) report_fail("reset screen_color", exp_color, screen_color);
  endtask

  task automatic reply_frames();
    logic [7:0] reply;
    logic [7:0] lo;
    run_frame(esp_pkg::get_cookie, 8'h00, 8'h00, 8'h00, 0, 1'b1, reply);
    if (reply !== 8'hAF) report_fail("get_cookie", 8'hAF, reply);
    run_frame(esp_pkg::get_version, 8'h00, 8'h00, 8'h00, 0, 1'b1, reply);
    if (reply !== 8'h03) report_fail("get_version", 8'h03, reply); // v0.3
    lo = 8'($urandom);
    bus.addr = {8'($urandom), lo}; // strobes stay released
    run_frame(esp_pkg::abus_read, 8'h00, 8'h00, 8'h00, 0, 1'b1, reply);
    if (reply !== lo) report_fail("abus_read", lo, reply);
  endtask

  task automatic led_color_keyb();
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
    logic [7:0] unused;
    int         kind;
    for (int n = 0; n < 20; n++) begin
      kind = $urandom_range(2);
      p0   = 8'($urandom);
      p1   = 8'($urandom);
      p2   = 8'($urandom);
      case (kind)
        0: begin
          run_frame(esp_pkg::set_led, p0, p1, p2, 1, 1'b0, unused);
          exp_led = {p0[0], p0[1], p0[2]}; // red, green, blue
        end
        1: begin
          run_frame(esp_pkg::set_screen_color, p0, p1, p2, 3, 1'b0, unused);
          exp_color = {p0, p1, p2};
        end
        default: begin
          run_frame(esp_pkg::send_keyb, p0, p1, p2, 2, 1'b0, unused);
          exp_rows[p0 % KEYB_ROWS] = p1; // row wraps
        end
      endcase
      if (led !== exp_led) report_fail("set_led", exp_led, led);
      if (screen_color !== exp_color) report_fail("set_screen_color", exp_color, screen_color);
      if (key_pressed !== keys_any()) report_fail("send_keyb", keys_any(), key_pressed);
    end
  endtask

  // one decoded access whose kind is the esp_s code
  task automatic run_access(input int kind);
    logic [15:0] addr;
    logic [7:0]  data;
    int          strobe;
    addr = 16'($urandom);
    data = 8'($urandom);
    case (kind)
      0: begin
        addr[7:0] = 8'd31;
        strobe    = STB_IN;
      end
      1: begin
        addr[7:0] = 8'd31;
        strobe    = STB_OUT;
      end
      2: begin
        addr[7:4] = 4'hC;
        strobe    = STB_IN;
      end
      3: begin
        addr[7:4] = 4'hC;
        strobe    = STB_OUT;
      end
      default: begin
        addr    = 16'h37E8;
        strobe  = STB_WR;
        exp_prn = data;
      end
    endcase
    req_seen = 1'b0;
    bus_access(addr, data, strobe);
    if (req_seen !== 1'b1) report_fail($sformatf("access %0d req", kind), 1, req_seen);
    if (esp_s !== 4'(kind)) report_fail($sformatf("access %0d esp_s", kind), kind, esp_s);
    wait_req_low();
    if (kind < 4) begin
      if (wait_req !== 1'b1) report_fail($sformatf("access %0d wait", kind), 1, wait_req);
    end else begin
      if (wait_req !== 1'b0) report_fail("printer wait", 0, wait_req); // no stall
    end
    pulse_done();
    wait_release();
    if (esp_s !== 4'hF) report_fail($sformatf("access %0d idle", kind), 4'hF, esp_s);
  endtask

  task automatic bus_requests();
    int          order [5];
    int          j;
    int          tmp;
    logic [15:0] addr;
    for (int i = 0; i < 5; i++) begin
      order[i] = i;
    end
    for (int i = 4; i > 0; i--) begin // shuffle
      j        = $urandom_range(i);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 5; i++) begin
      run_access(order[i]);
    end
    // ports outside both decodes
    for (int i = 0; i < 4; i++) begin
      addr = 16'($urandom);
      while (addr[7:0] == 8'd31 || addr[7:4] == 4'hC) begin
        addr[7:0] = addr[7:0] + 8'd1;
      end
      req_seen = 1'b0;
      bus_access(addr, 8'h00, (i % 2 == 0) ? STB_IN : STB_OUT);
      if (req_seen !== 1'b0) report_fail("miss req", 0, req_seen);
      if (esp_s !== 4'hF) report_fail("miss esp_s", 4'hF, esp_s);
    end
  endtask

  task automatic printer_flow();
    logic [7:0] data;
    logic [7:0] reply;
    data = 8'($urandom);
    bus_access(16'h37E8, data, STB_WR);
    exp_prn = data;
    bus_access(16'h37E8, 8'h00, STB_RD); // status read
    if (rd_data !== 8'hF0) report_fail("printer busy", 8'hF0, rd_data);
    run_frame(esp_pkg::get_printer_byte, 8'h00, 8'h00, 8'h00, 0, 1'b1, reply);
    if (reply !== exp_prn) report_fail("get_printer_byte", exp_prn, reply);
    wait_req_low();
    pulse_done();
    wait_release();
    bus_access(16'h37E8, 8'h00, STB_RD);
    if (rd_data !== 8'h30) report_fail("printer ready", 8'h30, rd_data);
  endtask

  task automatic intr_flag();
    logic [7:0] unused;
    run_frame(esp_pkg::data_ready, 8'h00, 8'h00, 8'h00, 0, 1'b0, unused);
    exp_intr = 1'b1;
    if (intr !== exp_intr) report_fail("data_ready set", exp_intr, intr);
    bus_access({8'($urandom), 8'd31}, 8'h00, STB_OUT); // port 31 clears
    exp_intr = 1'b0;
    if (intr !== exp_intr) report_fail("data_ready clear", exp_intr, intr);
    wait_req_low();
    pulse_done();
    wait_release();
  endtask

  initial begin
    void'($urandom(32'hf35b));
    clk       = 1'b0;
    rst       = 1'b1;
    sck       = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    done      = 1'b0;
    bus.addr  = 16'h0000;
    bus.data  = 8'h00;
    bus.rd_n  = 1'b1;
    bus.wr_n  = 1'b1;
    bus.in_n  = 1'b1;
    bus.out_n = 1'b1;
    errors    = 0;
    req_seen  = 1'b0;
    model_reset();
    repeat (4) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk); // synchronizers fill
    reset_values();
    reply_frames();
    led_color_keyb();
    bus_requests();
    printer_flow();
    intr_flag();
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
design/esp_pkg.sv
design/sync_edge.sv
design/spi_slave.sv
design/cmd_parser.sv
design/cmd_exec.sv
design/io_request.sv
design/trs_esp_bridge.sv
bench/tb_trs_esp_bridge.sv
